// ==== rtl/gcn_pkg.sv ====
package gcn_pkg;

    // element and lane geometry
    localparam int fv_size              = 8;
    localparam int mult_per_pe          = 4;
    localparam int max_fv_num           = 16;
    localparam int max_num_weight_layer = 4;
    localparam int max_groups           = max_fv_num / mult_per_pe;

    // 16 products of two 8-bit values fit in 20 bits
    localparam int acc_width = 20;

    // host configuration port
    localparam int cfg_addr_width = 5;
    localparam int cfg_data_width = 32;

    // derived counter widths
    localparam int layer_width  = $clog2(max_num_weight_layer);
    localparam int group_width  = $clog2(max_groups);
    localparam int fv_num_width = $clog2(max_fv_num) + 1;

    // controller states
    localparam logic st_idle = 1'b0;
    localparam logic st_work = 1'b1;

    // address 0 carries job sizes, addresses 1..16 carry four weight lanes
    typedef union packed {
        struct packed {
            logic [cfg_data_width-layer_width-fv_num_width-1:0] reserved;
            logic [fv_num_width-1:0]                            num_fv;
            logic [layer_width-1:0]                             num_weight_layer;
        } ctrl;
        logic [mult_per_pe-1:0][fv_size-1:0] lanes;
    } cfg_word_u;

endpackage

// ==== rtl/weight_cfg_regs.sv ====
module weight_cfg_regs (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                cfg_write,
    input  logic [gcn_pkg::cfg_addr_width-1:0]                  cfg_addr,
    input  logic [gcn_pkg::cfg_data_width-1:0]                  cfg_wdata,
    input  logic                                                busy,
    output logic [gcn_pkg::layer_width-1:0]                     num_weight_layer,
    output logic [gcn_pkg::fv_num_width-1:0]                    num_fv,
    output logic                                                wr_en,
    output logic [gcn_pkg::layer_width-1:0]                     wr_layer,
    output logic [gcn_pkg::group_width-1:0]                     wr_group,
    output logic [gcn_pkg::mult_per_pe-1:0][gcn_pkg::fv_size-1:0] wr_lanes
);
    import gcn_pkg::*;

    cfg_word_u                 word;
    logic [cfg_addr_width-1:0] idx;
    logic                      ctrl_sel;
    logic                      lane_sel;

    assign word = cfg_wdata;

    // writes during a job are dropped
    assign ctrl_sel = cfg_write && !busy && (cfg_addr == '0);
    assign lane_sel = cfg_write && !busy && (cfg_addr != '0) &&
                      (cfg_addr <= cfg_addr_width'(max_num_weight_layer * max_groups));

    // word index, layer in the upper bits and group in the lower
    assign idx = cfg_addr - 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            // one layer of four features
            num_weight_layer <= '0;
            num_fv           <= fv_num_width'(mult_per_pe);
            wr_en            <= 1'b0;
        end else begin
            wr_en <= lane_sel;
            if (ctrl_sel) begin
                num_weight_layer <= word.ctrl.num_weight_layer;
                num_fv           <= word.ctrl.num_fv;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lane_sel) begin
            wr_layer <= idx[group_width +: layer_width];
            wr_group <= idx[group_width-1:0];
            wr_lanes <= word.lanes;
        end
    end

    // job size must be whole groups within the feature memory
    a_num_fv_legal: assert property (@(posedge clk) disable iff (reset)
        ctrl_sel |-> (word.ctrl.num_fv != '0) && (word.ctrl.num_fv[1:0] == 2'b00) &&
                     (word.ctrl.num_fv <= fv_num_width'(max_fv_num)));

endmodule

// ==== rtl/weight_buffer.sv ====
module weight_buffer (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                wr_en,
    input  logic [gcn_pkg::layer_width-1:0]                     wr_layer,
    input  logic [gcn_pkg::group_width-1:0]                     wr_group,
    input  logic [gcn_pkg::mult_per_pe-1:0][gcn_pkg::fv_size-1:0] wr_lanes,
    input  logic [gcn_pkg::layer_width-1:0]                     rd_layer,
    input  logic [gcn_pkg::group_width-1:0]                     rd_group,
    output logic [gcn_pkg::mult_per_pe-1:0][gcn_pkg::fv_size-1:0] rd_lanes
);
    import gcn_pkg::*;

    // one four-lane word per layer and group
    logic [max_num_weight_layer-1:0][max_groups-1:0][mult_per_pe-1:0][fv_size-1:0] mem;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem <= '0;
        end else if (wr_en) begin
            mem[wr_layer][wr_group] <= wr_lanes;
        end
    end

    // registered read, old data on a same-word write
    always_ff @(posedge clk) begin
        rd_lanes <= mem[rd_layer][rd_group];
    end

endmodule

// ==== rtl/weight_cntl.sv ====
module weight_cntl (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             fire,
    input  logic [gcn_pkg::layer_width-1:0]  num_weight_layer,
    input  logic [gcn_pkg::fv_num_width-1:0] num_fv,
    output logic [gcn_pkg::layer_width-1:0]  rd_layer,
    output logic [gcn_pkg::group_width-1:0]  rd_group,
    output logic                             weight_valid,
    output logic [gcn_pkg::group_width-1:0]  weight_group,
    output logic                             weight_last,
    output logic                             bank_sos,
    output logic                             bank_eos,
    output logic                             busy,
    output logic                             rs_idle
);
    import gcn_pkg::*;

    logic                   state;
    logic [layer_width-1:0] layer_cnt;
    logic [group_width-1:0] group_cnt;
    logic [group_width-1:0] group_last_idx;
    logic                   group_last;
    logic                   layer_last;
    logic                   first_beat;
    logic                   final_beat;
    logic                   eos_pre;

    // groups per layer minus one
    assign group_last_idx = group_width'(num_fv[fv_num_width-1:2] - 1'b1);

    assign group_last = (group_cnt == group_last_idx);
    assign layer_last = (layer_cnt == num_weight_layer);
    assign first_beat = (state == st_work) && (layer_cnt == '0) && (group_cnt == '0);
    assign final_beat = (state == st_work) && group_last && layer_last;

    assign rd_layer = layer_cnt;
    assign rd_group = group_cnt;
    assign busy     = (state == st_work);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            layer_cnt <= '0;
            group_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    layer_cnt <= '0;
                    group_cnt <= '0;
                    if (fire) begin
                        state <= st_work;
                    end
                end
                default: begin
                    if (group_last) begin
                        group_cnt <= '0;
                        if (layer_last) begin
                            state     <= st_idle;
                            layer_cnt <= '0;
                        end else begin
                            layer_cnt <= layer_cnt + 1'b1;
                        end
                    end else begin
                        group_cnt <= group_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // beat controls line up with the buffer read data
    always_ff @(posedge clk) begin
        if (reset) begin
            weight_valid <= 1'b0;
            weight_last  <= 1'b0;
            bank_sos     <= 1'b0;
            eos_pre      <= 1'b0;
            bank_eos     <= 1'b0;
            rs_idle      <= 1'b0;
        end else begin
            weight_valid <= (state == st_work);
            weight_last  <= (state == st_work) && group_last;
            bank_sos     <= first_beat;
            // eos waits one more stage for the mac result
            eos_pre      <= final_beat;
            bank_eos     <= eos_pre;
            rs_idle      <= (state == st_idle) && !fire;
        end
    end

    always_ff @(posedge clk) begin
        weight_group <= group_cnt;
    end

    a_no_fire_in_work: assert property (@(posedge clk) disable iff (reset)
        fire |-> (state == st_idle));

    a_sos_eos_apart: assert property (@(posedge clk) disable iff (reset)
        (bank_sos && bank_eos) |->
            (num_weight_layer == '0) && (num_fv == fv_num_width'(mult_per_pe)));

    a_layer_in_range: assert property (@(posedge clk) disable iff (reset)
        (state == st_work) |-> (layer_cnt <= num_weight_layer));

endmodule

// ==== rtl/vertex_mac.sv ====
module vertex_mac (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic [gcn_pkg::max_fv_num-1:0][gcn_pkg::fv_size-1:0]  feature,
    input  logic                                                 weight_valid,
    input  logic [gcn_pkg::group_width-1:0]                      weight_group,
    input  logic                                                 weight_last,
    input  logic [gcn_pkg::mult_per_pe-1:0][gcn_pkg::fv_size-1:0] rd_lanes,
    input  logic                                                 bank_eos,
    output logic                                                 result_valid,
    output logic [gcn_pkg::layer_width-1:0]                      result_layer,
    output logic [gcn_pkg::acc_width-1:0]                        result_data
);
    import gcn_pkg::*;

    logic [acc_width-1:0]   acc;
    logic [acc_width-1:0]   beat_sum;
    logic [acc_width-1:0]   total;
    logic [layer_width-1:0] layer_cnt;
    logic                   layer_done;

    // four lane products of this group
    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < mult_per_pe; i++) begin
            beat_sum = beat_sum +
                       acc_width'(feature[weight_group * mult_per_pe + i]) *
                       acc_width'(rd_lanes[i]);
        end
    end

    assign total      = acc + beat_sum;
    assign layer_done = weight_valid && weight_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc          <= '0;
            result_valid <= 1'b0;
            layer_cnt    <= '0;
        end else begin
            result_valid <= layer_done;
            if (weight_valid) begin
                acc <= weight_last ? '0 : total;
            end
            // layer numbering starts over for each job
            if (bank_eos) begin
                layer_cnt <= '0;
            end else if (layer_done) begin
                layer_cnt <= layer_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (layer_done) begin
            result_data  <= total;
            result_layer <= layer_cnt;
        end
    end

    // a layer end only comes on a valid beat, so every result follows one
    a_last_on_valid: assert property (@(posedge clk) disable iff (reset)
        weight_last |-> weight_valid);

endmodule

// ==== rtl/gcn_combine_top.sv ====
module gcn_combine_top (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 cfg_write,
    input  logic [gcn_pkg::cfg_addr_width-1:0]                   cfg_addr,
    input  logic [gcn_pkg::cfg_data_width-1:0]                   cfg_wdata,
    input  logic                                                 fire,
    input  logic [gcn_pkg::max_fv_num-1:0][gcn_pkg::fv_size-1:0]  feature,
    output logic                                                 rs_idle,
    output logic                                                 bank_sos,
    output logic                                                 bank_eos,
    output logic                                                 result_valid,
    output logic [gcn_pkg::layer_width-1:0]                      result_layer,
    output logic [gcn_pkg::acc_width-1:0]                        result_data
);
    import gcn_pkg::*;

    logic [layer_width-1:0]                num_weight_layer;
    logic [fv_num_width-1:0]               num_fv;
    logic                                  busy;
    logic                                  wr_en;
    logic [layer_width-1:0]                wr_layer;
    logic [group_width-1:0]                wr_group;
    logic [mult_per_pe-1:0][fv_size-1:0]   wr_lanes;
    logic [layer_width-1:0]                rd_layer;
    logic [group_width-1:0]                rd_group;
    logic [mult_per_pe-1:0][fv_size-1:0]   rd_lanes;
    logic                                  weight_valid;
    logic [group_width-1:0]                weight_group;
    logic                                  weight_last;

    weight_cfg_regs u_cfg_regs (
        .clk              (clk),
        .reset            (reset),
        .cfg_write        (cfg_write),
        .cfg_addr         (cfg_addr),
        .cfg_wdata        (cfg_wdata),
        .busy             (busy),
        .num_weight_layer (num_weight_layer),
        .num_fv           (num_fv),
        .wr_en            (wr_en),
        .wr_layer         (wr_layer),
        .wr_group         (wr_group),
        .wr_lanes         (wr_lanes)
    );

    weight_buffer u_buffer (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_layer (wr_layer),
        .wr_group (wr_group),
        .wr_lanes (wr_lanes),
        .rd_layer (rd_layer),
        .rd_group (rd_group),
        .rd_lanes (rd_lanes)
    );

    weight_cntl u_cntl (
        .clk              (clk),
        .reset            (reset),
        .fire             (fire),
        .num_weight_layer (num_weight_layer),
        .num_fv           (num_fv),
        .rd_layer         (rd_layer),
        .rd_group         (rd_group),
        .weight_valid     (weight_valid),
        .weight_group     (weight_group),
        .weight_last      (weight_last),
        .bank_sos         (bank_sos),
        .bank_eos         (bank_eos),
        .busy             (busy),
        .rs_idle          (rs_idle)
    );

    vertex_mac u_mac (
        .clk          (clk),
        .reset        (reset),
        .feature      (feature),
        .weight_valid (weight_valid),
        .weight_group (weight_group),
        .weight_last  (weight_last),
        .rd_lanes     (rd_lanes),
        .bank_eos     (bank_eos),
        .result_valid (result_valid),
        .result_layer (result_layer),
        .result_data  (result_data)
    );

endmodule

// ==== verif/tb_gcn_combine.sv ====
module tb_gcn_combine;
    timeunit 1ns;
    timeprecision 1ps;
    import gcn_pkg::*;

    // directed job, size sweep, then two jobs around the busy writes
    localparam int num_jobs       = 1 + 4 * max_num_weight_layer + 2;
    localparam int cfg_cycles     = num_jobs * (1 + max_num_weight_layer * max_groups);
    localparam int timeout_cycles = num_jobs * 80 + cfg_cycles + 10;

    logic                               clk = 1'b0;
    logic                               reset;
    logic                               cfg_write;
    logic [cfg_addr_width-1:0]          cfg_addr;
    logic [cfg_data_width-1:0]          cfg_wdata;
    logic                               fire;
    logic [max_fv_num-1:0][fv_size-1:0] feature;
    logic                               rs_idle;
    logic                               bank_sos;
    logic                               bank_eos;
    logic                               result_valid;
    logic [layer_width-1:0]             result_layer;
    logic [acc_width-1:0]               result_data;

    // reference copy of everything the host got accepted
    logic [fv_size-1:0]   w_model [max_num_weight_layer][max_fv_num];
    int                   model_layers;
    int                   model_num_fv;

    // job tracking, edges counted from the one that samples fire
    bit                   job_active = 1'b0;
    int                   edge_cnt;
    int                   job_groups;
    int                   job_layers;
    int                   since_reset;
    int                   jobs_done = 0;
    logic [acc_width-1:0] exp_dot [max_num_weight_layer];

    gcn_combine_top DUT (.*);

    always #4 clk = ~clk;

    task automatic announce_failure();
        $display("*** TEST FAILED ***");
    endtask

    task automatic report_value_error(input string name, input logic [31:0] expected,
                                      input logic [31:0] actual);
        $display("ERROR at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        announce_failure();
    endtask

    task automatic report_pulse_error(input string name, input bit expected);
        if (expected) begin
            $display("%s did not pulse at edge %0d after fire", name, edge_cnt);
        end else begin
            $display("%s pulsed when it should not have (time %0d ns)", name, $time);
        end
        announce_failure();
    endtask

    function automatic logic [acc_width-1:0] model_dot(input int layer);
        logic [acc_width-1:0] sum;
        sum = '0;
        for (int i = 0; i < model_num_fv; i++) begin
            sum += acc_width'(w_model[layer][i]) * acc_width'(feature[i]);
        end
        return sum;
    endfunction

    // one host write, from just after an edge to just after the next
    task automatic drive_cfg(input logic [cfg_addr_width-1:0] addr, input cfg_word_u word);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = word;
        @(posedge clk);
        #1;
        cfg_write = 1'b0;
    endtask

    task automatic write_sizes(input int num_fv, input int layers, input bit accepted);
        cfg_word_u word;
        word = '0;
        word.ctrl.num_fv           = fv_num_width'(num_fv);
        word.ctrl.num_weight_layer = layer_width'(layers - 1);
        drive_cfg('0, word);
        if (accepted) begin
            model_num_fv = num_fv;
            model_layers = layers;
        end
    endtask

    task automatic write_weights(input int layer, input int group,
                                 input logic [mult_per_pe-1:0][fv_size-1:0] lanes,
                                 input bit accepted);
        cfg_word_u word;
        word       = '0;
        word.lanes = lanes;
        drive_cfg(cfg_addr_width'(layer * max_groups + group + 1), word);
        if (accepted) begin
            for (int i = 0; i < mult_per_pe; i++) begin
                w_model[layer][group * mult_per_pe + i] = lanes[i];
            end
        end
    endtask

    task automatic load_random_job(input int num_fv, input int layers);
        for (int i = 0; i < max_fv_num; i++) begin
            feature[i] = fv_size'($urandom);
        end
        write_sizes(num_fv, layers, 1'b1);
        for (int l = 0; l < max_num_weight_layer; l++) begin
            for (int g = 0; g < max_groups; g++) begin
                write_weights(l, g, $urandom, 1'b1);
            end
        end
    endtask

    // fire, optionally hammer the config port while busy, wait for the end
    task automatic run_job(input bit busy_writes);
        int beats;
        while (rs_idle !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        beats = model_layers * model_num_fv / mult_per_pe;
        fire  = 1'b1;
        @(posedge clk);
        #1;
        fire = 1'b0;
        for (int n = 0; busy_writes && n < beats; n++) begin
            if (n % 2 == 0) begin
                write_sizes(max_fv_num, max_num_weight_layer, 1'b0);
            end else begin
                write_weights(n % max_num_weight_layer, n % max_groups, $urandom, 1'b0);
            end
        end
        while (job_active) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk) begin
        bit exp_idle;
        bit exp_res;
        int res_layer;
        int last_edge;
        if (reset) begin
            job_active  = 1'b0;
            since_reset = 0;
        end else begin
            if (job_active) begin
                edge_cnt++;
            end
            if (fire) begin
                job_active = 1'b1;
                edge_cnt   = 0;
                job_groups = model_num_fv / mult_per_pe;
                job_layers = model_layers;
                for (int l = 0; l < job_layers; l++) begin
                    exp_dot[l] = model_dot(l);
                end
            end
            last_edge = job_layers * job_groups + 2;
            exp_res   = 1'b0;
            res_layer = 0;
            // one result every G edges, first at G+2
            if (job_active && edge_cnt > 2 && (edge_cnt - 2) % job_groups == 0) begin
                exp_res   = 1'b1;
                res_layer = (edge_cnt - 2) / job_groups - 1;
            end
            exp_idle = job_active ? (edge_cnt == 0 || edge_cnt == last_edge) : (since_reset > 0);

            a_idle_level: assert (rs_idle === exp_idle) else begin
                report_value_error("rs_idle", 32'(exp_idle), 32'(rs_idle));
                $fatal(1);
            end
            a_sos_edge: assert (bank_sos === (job_active && edge_cnt == 2)) else begin
                report_pulse_error("bank_sos", job_active && edge_cnt == 2);
                $fatal(1);
            end
            a_eos_edge: assert (bank_eos === (job_active && edge_cnt == last_edge)) else begin
                report_pulse_error("bank_eos", job_active && edge_cnt == last_edge);
                $fatal(1);
            end
            a_result_edge: assert (result_valid === exp_res) else begin
                report_pulse_error("result_valid", exp_res);
                $fatal(1);
            end
            a_result_layer: assert (!exp_res || result_layer === layer_width'(res_layer))
            else begin
                report_value_error("result_layer", 32'(res_layer), 32'(result_layer));
                $fatal(1);
            end
            a_result_data: assert (!exp_res || result_data === exp_dot[res_layer]) else begin
                report_value_error("result_data", 32'(exp_dot[res_layer]), 32'(result_data));
                $fatal(1);
            end

            if (job_active && edge_cnt == last_edge) begin
                job_active = 1'b0;
                jobs_done++;
            end
            since_reset++;
        end
    end

    a_fire_when_idle: assert property (@(posedge clk) disable iff (reset) fire |-> rs_idle)
    else begin
        $display("fire was driven while rs_idle was low");
        announce_failure();
        $fatal(1);
    end

    a_sos_single: assert property (@(posedge clk) disable iff (reset) bank_sos |=> !bank_sos)
    else begin
        $display("bank_sos stayed high for more than one cycle");
        announce_failure();
        $fatal(1);
    end

    initial begin
        void'($urandom(32'h6040d050));
        reset        = 1'b1;
        cfg_write    = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        fire         = 1'b0;
        feature      = '0;
        model_layers = 1;
        model_num_fv = mult_per_pe;
        for (int l = 0; l < max_num_weight_layer; l++) begin
            for (int i = 0; i < max_fv_num; i++) begin
                w_model[l][i] = '0;
            end
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        // idle levels right after reset
        repeat (4) @(posedge clk);
        #1;

        // single layer of four known weights
        for (int i = 0; i < max_fv_num; i++) begin
            feature[i] = fv_size'(i + 3);
        end
        write_sizes(mult_per_pe, 1, 1'b1);
        write_weights(0, 0, {8'd9, 8'd7, 8'd5, 8'd2}, 1'b1);
        run_job(1'b0);

        for (int nf = mult_per_pe; nf <= max_fv_num; nf += mult_per_pe) begin
            for (int nl = 1; nl <= max_num_weight_layer; nl++) begin
                load_random_job(nf, nl);
                run_job(1'b0);
            end
        end

        // dropped writes during a job, then a rerun on the held values
        load_random_job(2 * mult_per_pe, 2);
        run_job(1'b1);
        run_job(1'b0);

        if (jobs_done != num_jobs) begin
            $display("only %0d of %0d jobs completed", jobs_done, num_jobs);
            announce_failure();
            $fatal(1);
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the jobs did not complete", timeout_cycles);
        announce_failure();
        $fatal(1);
    end

endmodule

// ==== project.f ====
rtl/gcn_pkg.sv
rtl/weight_cfg_regs.sv
rtl/weight_buffer.sv
rtl/weight_cntl.sv
rtl/vertex_mac.sv
rtl/gcn_combine_top.sv
verif/tb_gcn_combine.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, the exit status carries pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_gcn_combine -f project.f -o sim_tb \
    && ./obj_dir/sim_tb \
    || exit 1
